/* design/accum_pkg.sv */
package accum_pkg;

    // array size
    localparam int NUM_CORES = 4;
    localparam int CORE_W    = 2;

    // item memory geometry, 100 words per core
    localparam int MEM_DEPTH = 100;
    localparam int ADDR_W    = 7;
    localparam int DATA_W    = 32;

    // apb register map, byte offsets
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_MEM_ADDR = 8'h04;
    localparam logic [7:0] REG_MEM_DATA = 8'h08;
    localparam logic [7:0] REG_SRC      = 8'h0C;
    localparam logic [7:0] REG_STATUS   = 8'h10;
    localparam logic [7:0] REG_RES_SEL  = 8'h14;
    localparam logic [7:0] REG_RESULT   = 8'h18;

    // one item memory write, core field picks the target
    typedef struct packed {
        logic              en;
        logic [CORE_W-1:0] core;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

    // one symbol, seen by every core at once
    // cont low starts a new sequence
    typedef struct packed {
        logic              valid;
        logic              cont;
        logic [ADDR_W-1:0] index;
    } src_t;

    // readback source, live sum or held snapshot
    typedef struct packed {
        logic [CORE_W-1:0] core;
        logic              live;
    } res_sel_t;

endpackage

/* design/accum_core.sv */
`timescale 1ns/1ps
`default_nettype none

module accum_core
    import accum_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_wr_t           mem_wr,
    input  src_t              src,
    input  logic              snapshot,
    input  logic              live,
    output logic [DATA_W-1:0] acc,
    output logic              busy
);

    // item memory
    // contents undefined until software loads them
    logic [DATA_W-1:0] item_mem [MEM_DEPTH];

    // stage 1 holds the index for the read
    logic              s1_v;
    logic [ADDR_W-1:0] s1_idx;

    // stage 2 holds the word in the read register
    logic              s2_v;
    logic [DATA_W-1:0] rd_word;

    // running sum and snapshot copy
    logic [DATA_W-1:0] acc_live;
    logic [DATA_W-1:0] acc_held;

    // write port
    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            item_mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // stage valids travel with the symbol
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_v <= 1'b0;
            s2_v <= 1'b0;
        end else begin
            s1_v <= src.valid;
            s2_v <= s1_v;
        end
    end

    // index register loads with each symbol
    always_ff @(posedge clk) begin
        if (src.valid) begin
            s1_idx <= src.index;
        end
    end

    // registered read one cycle after the symbol
    always_ff @(posedge clk) begin
        if (s1_v) begin
            rd_word <= item_mem[s1_idx];
        end
    end

    // clear on sequence start and add two cycles later
    // clear wins as it belongs to the newer sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_live <= '0;
        end else if (src.valid && !src.cont) begin
            acc_live <= '0;
        end else if (s2_v) begin
            // wraps modulo 2^32
            acc_live <= acc_live + rd_word;
        end
    end

    // snapshot takes whatever has landed so far
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_held <= '0;
        end else if (snapshot) begin
            acc_held <= acc_live;
        end
    end

    assign acc  = live ? acc_live : acc_held;
    assign busy = src.valid | s1_v | s2_v;

    // software must stay inside the loaded range
    a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
        mem_wr.en |-> (mem_wr.addr < ADDR_W'(MEM_DEPTH)))
        else $error("item memory write beyond depth");

    a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
        src.valid |-> (src.index < ADDR_W'(MEM_DEPTH)))
        else $error("symbol index beyond depth");

    // a restart must not land on the last add of the old sequence
    a_no_clear_on_add: assert property (@(posedge clk) disable iff (rst)
        (src.valid && !src.cont) |-> !s2_v)
        else $error("accumulator clear and add in the same cycle");

endmodule

`default_nettype wire

/* design/core_array.sv */
`timescale 1ns/1ps
`default_nettype none

module core_array
    import accum_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_wr_t           mem_wr,
    input  src_t              src,
    input  logic              snapshot,
    input  res_sel_t          res_sel,
    output logic [DATA_W-1:0] result,
    output logic              busy
);

    // per core readback values
    logic [DATA_W-1:0] core_acc [NUM_CORES];

    // per core busy flags
    logic [NUM_CORES-1:0] core_busy;

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core

        // write request with en kept only for this core
        mem_wr_t core_wr;

        always_comb begin
            core_wr    = mem_wr;
            core_wr.en = mem_wr.en && (mem_wr.core == CORE_W'(i));
        end

        // src and snapshot go to every core unchanged
        accum_core u_core (
            .clk      (clk),
            .rst      (rst),
            .mem_wr   (core_wr),
            .src      (src),
            .snapshot (snapshot),
            .live     (res_sel.live),
            .acc      (core_acc[i]),
            .busy     (core_busy[i])
        );

    end

    // addressed readback of the selected core
    assign result = core_acc[res_sel.core];

    // busy while any core still has a symbol in flight
    assign busy = |core_busy;

endmodule

`default_nettype wire

/* design/accum_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module accum_regs
    import accum_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output mem_wr_t           mem_wr,
    output src_t              src,
    output logic              snapshot,
    output res_sel_t          res_sel,
    input  logic              busy,
    input  logic [DATA_W-1:0] result
);

    // access phase of a transfer
    logic access;
    logic wr_access;
    logic rd_access;

    // address decode
    logic mapped;
    logic read_only;

    // MEM_ADDR fields
    logic [CORE_W-1:0] mem_core;
    logic [ADDR_W-1:0] mem_idx;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    always_comb begin
        mapped    = 1'b0;
        read_only = 1'b0;
        case (paddr)
            REG_CTRL, REG_MEM_ADDR, REG_MEM_DATA, REG_SRC, REG_RES_SEL: begin
                mapped = 1'b1;
            end
            REG_STATUS, REG_RESULT: begin
                mapped    = 1'b1;
                read_only = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // no wait states
    assign pready  = 1'b1;

    // error on unmapped offsets and on writes to status or result
    assign pslverr = access && (!mapped || (pwrite && read_only));

    // write side, pulses last one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr   <= '0;
            src      <= '0;
            snapshot <= 1'b0;
            mem_core <= '0;
            mem_idx  <= '0;
            res_sel  <= '0;
        end else begin
            mem_wr.en <= 1'b0;
            src.valid <= 1'b0;
            snapshot  <= 1'b0;
            if (wr_access) begin
                case (paddr)
                    REG_CTRL: begin
                        snapshot <= pwdata[0];
                    end
                    REG_MEM_ADDR: begin
                        mem_core <= pwdata[8 +: CORE_W];
                        mem_idx  <= pwdata[ADDR_W-1:0];
                    end
                    REG_MEM_DATA: begin
                        mem_wr.en   <= 1'b1;
                        mem_wr.core <= mem_core;
                        mem_wr.addr <= mem_idx;
                        mem_wr.data <= pwdata[DATA_W-1:0];
                        // step to the next entry for burst loads
                        mem_idx     <= mem_idx + 1'b1;
                    end
                    REG_SRC: begin
                        src.valid <= 1'b1;
                        src.cont  <= pwdata[8];
                        src.index <= pwdata[ADDR_W-1:0];
                    end
                    REG_RES_SEL: begin
                        res_sel.core <= pwdata[CORE_W-1:0];
                        res_sel.live <= pwdata[4];
                    end
                    default: begin
                        // read-only and unmapped writes are dropped
                    end
                endcase
            end
        end
    end

    // read side, combinational in the access cycle
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                REG_MEM_ADDR: begin
                    prdata[8 +: CORE_W]  = mem_core;
                    prdata[ADDR_W-1:0]   = mem_idx;
                end
                REG_STATUS: begin
                    prdata[0] = busy;
                end
                REG_RES_SEL: begin
                    prdata[CORE_W-1:0] = res_sel.core;
                    prdata[4]          = res_sel.live;
                end
                REG_RESULT: begin
                    prdata[DATA_W-1:0] = result;
                end
                default: begin
                    // write-only or unmapped, read as zero
                    prdata = '0;
                end
            endcase
        end
    end

    // master holds address and direction through the transfer
    a_setup_stable: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> ($stable(paddr) && $stable(pwrite)))
        else $error("apb address or direction changed after setup");

    a_enable_needs_sel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel)
        else $error("apb penable without psel");

endmodule

`default_nettype wire

/* design/accum_top.sv */
`timescale 1ns/1ps
`default_nettype none

module accum_top
    import accum_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // register block to array
    mem_wr_t           mem_wr;
    src_t              src;
    logic              snapshot;
    res_sel_t          res_sel;

    // array back to register block
    logic              busy;
    logic [DATA_W-1:0] result;

    // apb slave, turns bus traffic into commands
    accum_regs u_regs (
        .clk (clk), .rst (rst),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata),
        .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .mem_wr (mem_wr), .src (src), .snapshot (snapshot), .res_sel (res_sel),
        .busy (busy), .result (result)
    );

    // lookup and accumulate cores
    core_array u_array (
        .clk (clk), .rst (rst),
        .mem_wr (mem_wr), .src (src), .snapshot (snapshot), .res_sel (res_sel),
        .result (result), .busy (busy)
    );

endmodule

`default_nettype wire

/* dv/accum_tb.sv */
`timescale 1ns/1ps

module accum_tb
    import accum_pkg::*;
();

    localparam int POLL_LIMIT = 50;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // set once the first symbol goes out
    logic src_seen;

    int errors;
    int checks;

    // random source
    logic [31:0] lfsr_q = 32'hd890_0a0e;

    // reference model with shadow memories and expected sums
    logic [DATA_W-1:0] shadow_mem [NUM_CORES][MEM_DEPTH];
    logic [DATA_W-1:0] exp_live [NUM_CORES];
    logic [DATA_W-1:0] exp_held [NUM_CORES];

    accum_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // retry until the index falls inside the memory
    function automatic logic [ADDR_W-1:0] rand_index();
        logic [31:0] v;
        v = take_bits(ADDR_W);
        while (v >= 32'(MEM_DEPTH)) begin
            v = take_bits(ADDR_W);
        end
        return v[ADDR_W-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    // setup, access, then back to idle
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        if (addr == REG_SRC) begin
            src_seen <= 1'b1;
        end
        @(posedge clk);
        penable <= 1'b1;
        // slave outputs settled by mid access cycle
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // mapped accesses expect no error
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_value($sformatf("pslverr on write %02h", addr), 32'd0, 32'(err));
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check_value($sformatf("pslverr on read %02h", addr), 32'd0, 32'(err));
    endtask

    // poll status until all cores drain
    task automatic wait_idle();
        logic [31:0] st;
        logic        idle;
        idle = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !idle; n++) begin
            reg_read(REG_STATUS, st);
            idle = !st[0];
        end
        if (!idle) begin
            errors++;
            $display("timeout: busy did not fall after %0d status polls", POLL_LIMIT);
        end
    endtask

    // model clears on cont low and always adds the word
    task automatic send_symbol(input logic cont, input logic [ADDR_W-1:0] idx);
        reg_write(REG_SRC, (32'(cont) << 8) | 32'(idx));
        for (int c = 0; c < NUM_CORES; c++) begin
            if (!cont) begin
                exp_live[c] = '0;
            end
            exp_live[c] = exp_live[c] + shadow_mem[c][idx];
        end
    endtask

    task automatic check_cores(input string name);
        logic [31:0] val;
        for (int c = 0; c < NUM_CORES; c++) begin
            reg_write(REG_RES_SEL, 32'h10 | 32'(c));
            reg_read(REG_RESULT, val);
            check_value($sformatf("%s core %0d live", name, c), exp_live[c], val);
            reg_write(REG_RES_SEL, 32'(c));
            reg_read(REG_RESULT, val);
            check_value($sformatf("%s core %0d held", name, c), exp_held[c], val);
        end
    endtask

    // nothing may start before software sends a symbol
    a_busy_before_src: assert property (@(posedge clk) disable iff (rst)
        !src_seen |-> !DUT.busy)
        else begin
            errors++;
            $display("busy went high before any symbol was sent");
        end

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            errors++;
            $display("pready dropped, the slave has no wait states");
        end

    // slave error only inside an access cycle
    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else begin
            errors++;
            $display("pslverr raised outside an access cycle");
        end

    initial begin
        logic [31:0]       val;
        logic              err;
        logic [31:0]       word;

        clk      = 1'b0;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        src_seen = 1'b0;
        errors   = 0;
        checks   = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_live[c] = '0;
            exp_held[c] = '0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // reset state
        reg_read(REG_STATUS, val);
        check_value("reset busy", 32'd0, val);
        reg_read(REG_MEM_ADDR, val);
        check_value("reset mem_addr", 32'd0, val);
        reg_read(REG_RES_SEL, val);
        check_value("reset res_sel", 32'd0, val);
        check_cores("reset");

        // burst load each core through the auto increment
        for (int c = 0; c < NUM_CORES; c++) begin
            reg_write(REG_MEM_ADDR, 32'(c) << 8);
            for (int a = 0; a < MEM_DEPTH; a++) begin
                word             = take_bits(DATA_W);
                shadow_mem[c][a] = word;
                reg_write(REG_MEM_DATA, word);
            end
            reg_read(REG_MEM_ADDR, val);
            check_value("load end address", (32'(c) << 8) | 32'(MEM_DEPTH), val);
        end

        // single lookups with one word per sequence
        for (int k = 0; k < 4; k++) begin
            send_symbol(1'b0, rand_index());
            wait_idle();
            check_cores("single lookup");
        end

        // back to back sequence of 20
        send_symbol(1'b0, rand_index());
        for (int k = 1; k < 20; k++) begin
            send_symbol(1'b1, rand_index());
        end
        wait_idle();
        check_cores("accumulation");

        // restart drops the old sum
        send_symbol(1'b0, rand_index());
        wait_idle();
        check_cores("restart");

        // snapshot then keep adding on top
        send_symbol(1'b0, rand_index());
        for (int k = 0; k < 4; k++) begin
            send_symbol(1'b1, rand_index());
        end
        wait_idle();
        reg_write(REG_CTRL, 32'h1);
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_held[c] = exp_live[c];
        end
        for (int k = 0; k < 6; k++) begin
            send_symbol(1'b1, rand_index());
        end
        wait_idle();
        check_cores("snapshot");

        // bus errors must leave state untouched
        reg_write(REG_MEM_ADDR, 32'h0000_012a);
        reg_write(REG_RES_SEL, 32'h12);
        apb_read(8'h1C, val, err);
        check_value("unmapped read pslverr", 32'd1, 32'(err));
        apb_write(REG_STATUS, 32'hffff_ffff, err);
        check_value("status write pslverr", 32'd1, 32'(err));
        apb_write(REG_RESULT, 32'hdead_beef, err);
        check_value("result write pslverr", 32'd1, 32'(err));
        reg_read(REG_RES_SEL, val);
        check_value("bus error res_sel", 32'h12, val);
        reg_read(REG_MEM_ADDR, val);
        check_value("bus error mem_addr", 32'h0000_012a, val);
        reg_read(REG_STATUS, val);
        check_value("bus error busy", 32'd0, val);
        check_cores("bus error");

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
design/accum_pkg.sv
design/accum_core.sv
design/core_array.sv
design/accum_regs.sv
design/accum_top.sv
dv/accum_tb.sv

/* Makefile */
# verilator build and run for the accumulator array

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= accum_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, the simulator output is echoed as is
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
